//--- verilog/bp_settings.svh
// table sizes and pc width for the branch predictor, included by every file that sizes storage
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// number of btb entries, must be a power of two
`define BP_BTB_ENTRIES 32

// global history width, also the pht index width
`define BP_GHR_BITS 5

`define BP_ADDR_BITS 32

`endif

//--- verilog/riscv_pkg.sv
// rv32i instruction encodings used by the fetch-stage predictor to classify control flow
`default_nettype none

package riscv_pkg;

    // bits [6:0] of every rv32i instruction
    typedef logic [6:0] opcode_t;

    // jump and link, always taken
    localparam opcode_t OP_JAL    = 7'b1101111;

    // register-indirect jump, also always taken
    localparam opcode_t OP_JALR   = 7'b1100111;

    // beq, bne, blt, bge, bltu, bgeu share one opcode
    localparam opcode_t OP_BRANCH = 7'b1100011;

endpackage : riscv_pkg

`default_nettype wire

//--- verilog/bp_pkg.sv
// types shared by the btb and the gshare direction predictor, sized from the settings header
`default_nettype none

`include "bp_settings.svh"

package bp_pkg;

    localparam int BTB_IDX_BITS = $clog2(`BP_BTB_ENTRIES);

    // 2-bit saturating counter, upper bit set means taken
    typedef logic [1:0] ctr_t;

    // weakly not taken
    localparam ctr_t CTR_RESET = 2'd1;

    typedef enum logic {
        KIND_BRANCH = 1'b0,
        KIND_JUMP   = 1'b1
    } btb_kind_t;

    typedef logic [BTB_IDX_BITS-1:0] btb_idx_t;

    typedef logic [`BP_GHR_BITS-1:0] pht_idx_t;

endpackage : bp_pkg

`default_nettype wire

//--- verilog/bp_btb.sv
// direct-mapped branch target buffer; looks up the fetch pc and is written by resolved jumps/branches
`default_nettype none
`timescale 1ns/10ps

`include "bp_settings.svh"

module bp_btb (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,

    // fetch side
    input  wire logic [`BP_ADDR_BITS-1:0] pc_i,
    input  wire logic                     pht_taken_i,

    // resolution from execute
    input  wire logic                     upd_valid_i,
    input  wire logic [`BP_ADDR_BITS-1:0] upd_pc_i,
    input  wire riscv_pkg::opcode_t       upd_op_i,
    input  wire logic [`BP_ADDR_BITS-1:0] upd_target_i,

    output logic                          pht_upd_o,
    output logic                          pred_taken_o,
    output logic [`BP_ADDR_BITS-1:0]      pred_target_o
);

    localparam int IDX_LSB  = 2;
    localparam int TAG_LSB  = IDX_LSB + bp_pkg::BTB_IDX_BITS;
    localparam int TAG_BITS = `BP_ADDR_BITS - TAG_LSB;

    logic [`BP_BTB_ENTRIES-1:0] valid_q;
    logic [TAG_BITS-1:0]        tag_mem    [`BP_BTB_ENTRIES];
    bp_pkg::btb_kind_t          kind_mem   [`BP_BTB_ENTRIES];
    logic [`BP_ADDR_BITS-1:0]   target_mem [`BP_BTB_ENTRIES];

    bp_pkg::btb_idx_t    rd_idx;
    logic [TAG_BITS-1:0] rd_tag;
    logic                rd_hit;

    bp_pkg::btb_idx_t    wr_idx;
    logic [TAG_BITS-1:0] wr_tag;
    logic                upd_is_jump;
    logic                upd_is_branch;
    logic                wr_en;

    assign rd_idx = pc_i[TAG_LSB-1:IDX_LSB];
    assign rd_tag = pc_i[`BP_ADDR_BITS-1:TAG_LSB];

    assign wr_idx = upd_pc_i[TAG_LSB-1:IDX_LSB];
    assign wr_tag = upd_pc_i[`BP_ADDR_BITS-1:TAG_LSB];

    // opcode classification happens only here
    assign upd_is_jump   = (upd_op_i == riscv_pkg::OP_JAL) || (upd_op_i == riscv_pkg::OP_JALR);
    assign upd_is_branch = (upd_op_i == riscv_pkg::OP_BRANCH);
    assign wr_en         = upd_valid_i && (upd_is_jump || upd_is_branch);

    // conditional branches also train the direction predictor
    assign pht_upd_o = upd_valid_i && upd_is_branch;

    assign rd_hit = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

    always_comb begin
        pred_taken_o = 1'b0;
        if (rd_hit) begin
            // jumps always go, branches follow the pht
            pred_taken_o = (kind_mem[rd_idx] == bp_pkg::KIND_JUMP) || pht_taken_i;
        end
    end

    assign pred_target_o = pred_taken_o ? target_mem[rd_idx] : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // entry payload, whole entry is rewritten on every accepted update
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            kind_mem[wr_idx]   <= upd_is_jump ? bp_pkg::KIND_JUMP : bp_pkg::KIND_BRANCH;
            target_mem[wr_idx] <= upd_target_i;
        end
    end

endmodule : bp_btb

`default_nettype wire

//--- verilog/bp_gshare.sv
// gshare direction predictor: global history xor pc indexes a table of 2-bit counters
`default_nettype none
`timescale 1ns/10ps

`include "bp_settings.svh"

module bp_gshare (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,
    input  wire logic [`BP_ADDR_BITS-1:0] pc_i,
    input  wire logic                     ghr_clear_i,

    // training from a resolved conditional branch
    input  wire logic                     pht_upd_i,
    input  wire logic                     upd_taken_i,
    input  wire bp_pkg::pht_idx_t         upd_pht_index_i,

    output bp_pkg::pht_idx_t              pht_index_o,
    output logic                          pht_taken_o
);

    localparam int PHT_ENTRIES = 1 << `BP_GHR_BITS;

    bp_pkg::pht_idx_t ghr_q;
    bp_pkg::ctr_t     pht_q [PHT_ENTRIES];

    bp_pkg::ctr_t     upd_ctr;
    bp_pkg::ctr_t     next_ctr;

    assign pht_index_o = pc_i[`BP_GHR_BITS+1:2] ^ ghr_q;
    assign pht_taken_o = pht_q[pht_index_o][1];

    assign upd_ctr = pht_q[upd_pht_index_i];

    // saturate at 0 and 3
    always_comb begin
        next_ctr = upd_ctr;
        if (upd_taken_i && (upd_ctr != 2'b11)) begin
            next_ctr = upd_ctr + 2'd1;
        end else if (!upd_taken_i && (upd_ctr != 2'b00)) begin
            next_ctr = upd_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= bp_pkg::CTR_RESET;
            end
        end else if (pht_upd_i) begin
            pht_q[upd_pht_index_i] <= next_ctr;
        end
    end

    // clear wins over a shift in the same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr_q <= '0;
        end else if (ghr_clear_i) begin
            ghr_q <= '0;
        end else if (pht_upd_i) begin
            ghr_q <= {ghr_q[`BP_GHR_BITS-2:0], upd_taken_i};
        end
    end

endmodule : bp_gshare

`default_nettype wire

//--- verilog/branch_predictor.sv
// fetch-stage branch predictor top, joins the btb with the gshare direction predictor
`default_nettype none
`timescale 1ns/10ps

`include "bp_settings.svh"

module branch_predictor (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,

    // prediction for the current fetch pc
    input  wire logic [`BP_ADDR_BITS-1:0] pc_i,
    output logic                          pred_taken_o,
    output logic [`BP_ADDR_BITS-1:0]      pred_target_o,
    output bp_pkg::pht_idx_t              pred_pht_index_o,

    // resolution from execute
    input  wire logic                     upd_valid_i,
    input  wire logic [`BP_ADDR_BITS-1:0] upd_pc_i,
    input  wire logic [6:0]               upd_op_i,
    input  wire logic                     upd_taken_i,
    input  wire logic [`BP_ADDR_BITS-1:0] upd_target_i,
    input  wire bp_pkg::pht_idx_t         upd_pht_index_i,

    input  wire logic                     ghr_clear_i
);

    logic pht_taken;
    logic pht_upd;

    bp_btb btb0 (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .pc_i          (pc_i),
        .pht_taken_i   (pht_taken),
        .upd_valid_i   (upd_valid_i),
        .upd_pc_i      (upd_pc_i),
        .upd_op_i      (upd_op_i),
        .upd_target_i  (upd_target_i),
        .pht_upd_o     (pht_upd),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

    // upd_taken_i rides along with the branch strobe from the btb
    bp_gshare gshare0 (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .pc_i            (pc_i),
        .ghr_clear_i     (ghr_clear_i),
        .pht_upd_i       (pht_upd),
        .upd_taken_i     (upd_taken_i),
        .upd_pht_index_i (upd_pht_index_i),
        .pht_index_o     (pred_pht_index_o),
        .pht_taken_o     (pht_taken)
    );

endmodule : branch_predictor

`default_nettype wire

//--- testbench/branch_predictor_chk.sv
// concurrent property checks on the predictor top, attached to branch_predictor by bind
`default_nettype none
`timescale 1ns/10ps

`include "bp_settings.svh"

module branch_predictor_chk (
    input wire logic                     clk,
    input wire logic                     arst_n_i,
    input wire logic [`BP_ADDR_BITS-1:0] pc_i,
    input wire logic                     ghr_clear_i,
    input wire logic                     pred_taken_i,
    input wire logic [`BP_ADDR_BITS-1:0] pred_target_i,
    input wire logic [`BP_GHR_BITS-1:0]  pht_index_i
);

    // no prediction means no target either
    target_zero_when_not_taken: assert property (
        @(posedge clk) !pred_taken_i |-> (pred_target_i == '0)
    ) else $error("target is nonzero while no branch is predicted taken");

    no_taken_in_reset: assert property (
        @(posedge clk) !arst_n_i |-> !pred_taken_i
    ) else $error("a branch is predicted taken while reset is held");

    // empty history leaves the plain pc index
    plain_index_after_clear: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ghr_clear_i |=> (pht_index_i == pc_i[`BP_GHR_BITS+1:2])
    ) else $error("pht index is not the plain pc index after a history clear");

endmodule : branch_predictor_chk

bind branch_predictor branch_predictor_chk chk0 (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .pc_i          (pc_i),
    .ghr_clear_i   (ghr_clear_i),
    .pred_taken_i  (pred_taken_o),
    .pred_target_i (pred_target_o),
    .pht_index_i   (pred_pht_index_o)
);

`default_nettype wire

//--- testbench/branch_predictor_tb.sv
// self-checking testbench for branch_predictor with directed cases and a random run against a model
`default_nettype none
`timescale 1ns/10ps

`include "bp_settings.svh"

module branch_predictor_tb;

    localparam int HALF          = 20;
    localparam int IDX_BITS      = $clog2(`BP_BTB_ENTRIES);
    localparam int TAG_LSB       = 2 + IDX_BITS;
    localparam int PHT_ENTRIES   = 1 << `BP_GHR_BITS;
    localparam int RANDOM_CYCLES = 4000;

    logic                    clk = 1'b0;
    logic                    arst_n_i;
    logic [31:0]             pc_i;
    logic                    pred_taken_o;
    logic [31:0]             pred_target_o;
    logic [`BP_GHR_BITS-1:0] pred_pht_index_o;
    logic                    upd_valid_i;
    logic [31:0]             upd_pc_i;
    logic [6:0]              upd_op_i;
    logic                    upd_taken_i;
    logic [31:0]             upd_target_i;
    logic [`BP_GHR_BITS-1:0] upd_pht_index_i;
    logic                    ghr_clear_i;

    // reference model state
    logic                    m_valid  [`BP_BTB_ENTRIES];
    logic [31:0]             m_tag    [`BP_BTB_ENTRIES];
    logic                    m_jump   [`BP_BTB_ENTRIES];
    logic [31:0]             m_target [`BP_BTB_ENTRIES];
    logic [1:0]              m_ctr    [PHT_ENTRIES];
    logic [`BP_GHR_BITS-1:0] m_ghr;

    logic [31:0]             pool [8];

    branch_predictor dut0 (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .pc_i             (pc_i),
        .pred_taken_o     (pred_taken_o),
        .pred_target_o    (pred_target_o),
        .pred_pht_index_o (pred_pht_index_o),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_op_i         (upd_op_i),
        .upd_taken_i      (upd_taken_i),
        .upd_target_i     (upd_target_i),
        .upd_pht_index_i  (upd_pht_index_i),
        .ghr_clear_i      (ghr_clear_i)
    );

    always #HALF clk = ~clk;

    function automatic logic [`BP_GHR_BITS-1:0] plain_index(input logic [31:0] pc);
        return pc[`BP_GHR_BITS+1:2];
    endfunction

    function automatic void predict(input logic [31:0] pc, output logic taken,
                                    output logic [31:0] target,
                                    output logic [`BP_GHR_BITS-1:0] index);
        logic [IDX_BITS-1:0] bi;
        logic                hit;
        bi     = pc[TAG_LSB-1:2];
        index  = pc[`BP_GHR_BITS+1:2] ^ m_ghr;
        hit    = m_valid[bi] && (m_tag[bi] == (pc >> TAG_LSB));
        taken  = hit && (m_jump[bi] || m_ctr[index][1]);
        target = taken ? m_target[bi] : 32'h0;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_ctr[i] = 2'd1;
        end
        m_ghr = '0;
    endtask

    task automatic update_model();
        logic [IDX_BITS-1:0] bi;
        logic                is_jump;
        logic                is_branch;
        bi        = upd_pc_i[TAG_LSB-1:2];
        is_jump   = (upd_op_i == riscv_pkg::OP_JAL) || (upd_op_i == riscv_pkg::OP_JALR);
        is_branch = (upd_op_i == riscv_pkg::OP_BRANCH);
        if (upd_valid_i && (is_jump || is_branch)) begin
            m_valid[bi]  = 1'b1;
            m_tag[bi]    = upd_pc_i >> TAG_LSB;
            m_jump[bi]   = is_jump;
            m_target[bi] = upd_target_i;
        end
        if (upd_valid_i && is_branch) begin
            if (upd_taken_i && (m_ctr[upd_pht_index_i] != 2'd3)) begin
                m_ctr[upd_pht_index_i] = m_ctr[upd_pht_index_i] + 2'd1;
            end else if (!upd_taken_i && (m_ctr[upd_pht_index_i] != 2'd0)) begin
                m_ctr[upd_pht_index_i] = m_ctr[upd_pht_index_i] - 2'd1;
            end
        end
        if (ghr_clear_i) begin
            m_ghr = '0;
        end else if (upd_valid_i && is_branch) begin
            m_ghr = {m_ghr[`BP_GHR_BITS-2:0], upd_taken_i};
        end
    endtask

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reset_model();
        end else begin
            update_model();
        end
    end

    task automatic report_failure();
        $display("Finished with errors");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_outputs(input logic exp_taken, input logic [31:0] exp_target,
                                 input logic [`BP_GHR_BITS-1:0] exp_index);
        assert (pred_taken_o === exp_taken) else begin
            $display("MISMATCH pred_taken_o: got %h, expected %h", pred_taken_o, exp_taken);
            report_failure();
        end
        assert (pred_target_o === exp_target) else begin
            $display("MISMATCH pred_target_o: got %h, expected %h", pred_target_o, exp_target);
            report_failure();
        end
        assert (pred_pht_index_o === exp_index) else begin
            $display("MISMATCH pred_pht_index_o: got %h, expected %h",
                     pred_pht_index_o, exp_index);
            report_failure();
        end
    endtask

    // outputs are settled 1 ns before the rising edge
    initial begin
        logic                    exp_taken;
        logic [31:0]             exp_target;
        logic [`BP_GHR_BITS-1:0] exp_index;
        forever begin
            @(negedge clk);
            #(HALF - 1);
            predict(pc_i, exp_taken, exp_target, exp_index);
            check_outputs(exp_taken, exp_target, exp_index);
        end
    end

    // one cycle of update inputs, the returned index is the one fetch saw for that pc
    task automatic drive_cycle(input logic valid, input logic [31:0] pc, input logic [6:0] op,
                               input logic taken, input logic [31:0] target, input logic clear);
        logic                    p_taken;
        logic [31:0]             p_target;
        logic [`BP_GHR_BITS-1:0] p_index;
        predict(pc, p_taken, p_target, p_index);
        upd_valid_i     = valid;
        upd_pc_i        = pc;
        upd_op_i        = op;
        upd_taken_i     = taken;
        upd_target_i    = target;
        upd_pht_index_i = p_index;
        ghr_clear_i     = clear;
        @(negedge clk);
        upd_valid_i = 1'b0;
        ghr_clear_i = 1'b0;
    endtask

    task automatic expect_prediction(input logic [31:0] pc, input logic exp_taken,
                                     input logic [31:0] exp_target,
                                     input logic [`BP_GHR_BITS-1:0] exp_index);
        pc_i = pc;
        #1;
        check_outputs(exp_taken, exp_target, exp_index);
        @(negedge clk);
    endtask

    initial begin
        int         k;
        logic [6:0] op;
        logic       taken;
        void'($urandom(69));
        arst_n_i        = 1'b1;
        pc_i            = '0;
        upd_valid_i     = 1'b0;
        upd_pc_i        = '0;
        upd_op_i        = '0;
        upd_taken_i     = 1'b0;
        upd_target_i    = '0;
        upd_pht_index_i = '0;
        ghr_clear_i     = 1'b0;
        // each pool pc gets btb index i, pc 1 then aliases pc 0 with another tag
        for (int i = 0; i < 8; i++) begin
            pool[i] = ($urandom & ~32'h0000_007F) | (32'(i) << 2);
        end
        pool[1] = pool[0] ^ 32'h0001_0000;
        #1;
        arst_n_i = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        for (int i = 0; i < 8; i++) begin
            expect_prediction(pool[i], 1'b0, 32'h0, plain_index(pool[i]));
        end

        drive_cycle(1'b1, pool[0], riscv_pkg::OP_JAL, 1'b1, 32'h0000_1000, 1'b0);
        expect_prediction(pool[0], 1'b1, 32'h0000_1000, plain_index(pool[0]));
        drive_cycle(1'b1, pool[0], riscv_pkg::OP_JALR, 1'b1, 32'h0000_2468, 1'b0);
        expect_prediction(pool[0], 1'b1, 32'h0000_2468, plain_index(pool[0]));

        expect_prediction(pool[1], 1'b0, 32'h0, plain_index(pool[1]));
        drive_cycle(1'b1, pool[1], riscv_pkg::OP_JAL, 1'b1, 32'h0000_3000, 1'b0);
        expect_prediction(pool[1], 1'b1, 32'h0000_3000, plain_index(pool[1]));
        expect_prediction(pool[0], 1'b0, 32'h0, plain_index(pool[0]));

        // history is cleared on every update so the counter index stays put
        for (int i = 0; i < 5; i++) begin
            drive_cycle(1'b1, pool[2], riscv_pkg::OP_BRANCH, 1'b1, 32'h0000_4000, 1'b1);
        end
        expect_prediction(pool[2], 1'b1, 32'h0000_4000, plain_index(pool[2]));
        drive_cycle(1'b1, pool[2], riscv_pkg::OP_BRANCH, 1'b0, 32'h0000_4000, 1'b1);
        expect_prediction(pool[2], 1'b1, 32'h0000_4000, plain_index(pool[2]));
        drive_cycle(1'b1, pool[2], riscv_pkg::OP_BRANCH, 1'b0, 32'h0000_4000, 1'b1);
        expect_prediction(pool[2], 1'b0, 32'h0, plain_index(pool[2]));
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, pool[2], riscv_pkg::OP_BRANCH, 1'b0, 32'h0000_4000, 1'b1);
        end
        drive_cycle(1'b1, pool[2], riscv_pkg::OP_BRANCH, 1'b1, 32'h0000_4000, 1'b1);
        expect_prediction(pool[2], 1'b0, 32'h0, plain_index(pool[2]));
        drive_cycle(1'b1, pool[2], riscv_pkg::OP_BRANCH, 1'b1, 32'h0000_4000, 1'b1);
        expect_prediction(pool[2], 1'b1, 32'h0000_4000, plain_index(pool[2]));

        // with history 1 pc 3 aliases onto the counter trained by pc 2
        drive_cycle(1'b1, pool[3], riscv_pkg::OP_BRANCH, 1'b1, 32'h0000_5000, 1'b0);
        expect_prediction(pool[3], 1'b1, 32'h0000_5000, plain_index(pool[3]) ^ 5'b00001);
        drive_cycle(1'b1, pool[3], riscv_pkg::OP_BRANCH, 1'b0, 32'h0000_5000, 1'b0);
        expect_prediction(pool[3], 1'b0, 32'h0, plain_index(pool[3]) ^ 5'b00010);
        drive_cycle(1'b1, pool[3], 7'b0110011, 1'b1, 32'h0000_6000, 1'b0);
        expect_prediction(pool[3], 1'b0, 32'h0, plain_index(pool[3]) ^ 5'b00010);
        drive_cycle(1'b1, pool[4], 7'b0010011, 1'b1, 32'h0000_7000, 1'b0);
        expect_prediction(pool[4], 1'b0, 32'h0, plain_index(pool[4]) ^ 5'b00010);
        // plain index of pc 3 reaches its own counter again, trained to weakly taken
        drive_cycle(1'b0, pool[3], 7'b0000000, 1'b0, 32'h0, 1'b1);
        expect_prediction(pool[3], 1'b1, 32'h0000_5000, plain_index(pool[3]));

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            k = $urandom_range(7, 0);
            pc_i = pool[k];
            k = $urandom_range(7, 0);
            case ($urandom_range(3, 0))
                0: op = riscv_pkg::OP_JAL;
                1: op = riscv_pkg::OP_JALR;
                2: op = riscv_pkg::OP_BRANCH;
                default: op = 7'b0110011;
            endcase
            taken = (op == riscv_pkg::OP_JAL) || (op == riscv_pkg::OP_JALR) ||
                    ($urandom_range(1, 0) == 1);
            drive_cycle(($urandom_range(1, 0) == 1), pool[k], op, taken,
                        $urandom & 32'hFFFF_FFFC, ($urandom_range(15, 0) == 0));
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule : branch_predictor_tb

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/riscv_pkg.sv
verilog/bp_pkg.sv
verilog/bp_btb.sv
verilog/bp_gshare.sv
verilog/branch_predictor.sv
testbench/branch_predictor_chk.sv
testbench/branch_predictor_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the branch predictor testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module branch_predictor_tb -o sim_bp

./obj_dir/sim_bp 2>&1 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
